// ==== uart_dbg_top.f ====
+incdir+logic
logic/uart_dbg_proto_pkg.sv
logic/uart_dbg_bus_pkg.sv
logic/uart_rx_deser.sv
logic/dbg_cmd_engine.sv
logic/tx_byte_queue.sv
logic/uart_tx_ser.sv
logic/uart_dbg_top.sv
verification/uart_dbg_tb.sv

// ==== verification/uart_dbg_tb.sv ====
`timescale 1ns/1ps
`include "uart_dbg_defines.svh"

module uart_dbg_tb;

  localparam int clks_per_bit = `UART_DBG_CLKS_PER_BIT;
  // About 60 bytes each way at 160 clocks per byte, with wide margin
  localparam int max_cycles   = 200000;

  logic                        clk;
  logic                        rst_i;
  logic                        uart_rx_i;
  logic                        uart_tx_o;
  logic                        psel_o;
  logic                        penable_o;
  logic                        pwrite_o;
  uart_dbg_bus_pkg::apb_addr_t paddr_o;
  uart_dbg_bus_pkg::apb_data_t pwdata_o;
  uart_dbg_bus_pkg::apb_data_t prdata_i;
  logic                        pready_i;

  // Frames seen on uart_tx_o, oldest first
  uart_dbg_proto_pkg::byte_t   got_q[$];
  // Writes the host has asked for and the bus has not yet shown
  uart_dbg_bus_pkg::apb_addr_t exp_addr_q[$];
  uart_dbg_bus_pkg::apb_data_t exp_data_q[$];
  uart_dbg_bus_pkg::apb_data_t exp_mem[uart_dbg_bus_pkg::apb_addr_t];
  uart_dbg_bus_pkg::apb_data_t apb_mem[uart_dbg_bus_pkg::apb_addr_t];
  int                          xfer_cnt;
  int                          wait_cnt;
  int                          cycle_cnt;
  logic                        cmd_started;

  uart_dbg_top DUT (
    .clk      (clk),
    .rst_i    (rst_i),
    .uart_rx_i(uart_rx_i),
    .uart_tx_o(uart_tx_o),
    .psel_o   (psel_o),
    .penable_o(penable_o),
    .pwrite_o (pwrite_o),
    .paddr_o  (paddr_o),
    .pwdata_o (pwdata_o),
    .prdata_i (prdata_i),
    .pready_i (pready_i)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == max_cycles) begin
      abort_run($sformatf("Timeout: run still busy after %0d clock cycles", max_cycles));
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // APB slave model
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (rst_i) begin
      pready_i <= 1'b0;
      wait_cnt = 0;
    end else if (psel_o && !penable_o) begin
      // 0 to 3 wait states per transfer
      wait_cnt = $urandom_range(3, 0);
      pready_i <= wait_cnt == 0;
      prdata_i <= apb_mem.exists(paddr_o) ? apb_mem[paddr_o] : 8'h9a;
    end else if (psel_o && penable_o && pready_i) begin
      pready_i <= 1'b0;
      xfer_cnt = xfer_cnt + 1;
      if (pwrite_o) begin
        $display("%0t ns APB write %h <= %h", $time, paddr_o, pwdata_o);
        apb_mem[paddr_o] = pwdata_o;
        assert (exp_addr_q.size() != 0)
          else abort_run("APB write issued with no data byte sent for it");
        assert (paddr_o == exp_addr_q[0] && pwdata_o == exp_data_q[0])
          else abort_run($sformatf("Mismatch at %0t ns: APB write %h <= %h, expected %h <= %h",
                                   $time, paddr_o, pwdata_o, exp_addr_q[0], exp_data_q[0]));
        exp_addr_q.delete(0);
        exp_data_q.delete(0);
      end
    end else if (psel_o && penable_o) begin
      wait_cnt = wait_cnt - 1;
      pready_i <= wait_cnt == 0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Bus and line checkers
  ////////////////////////////////////////////////////////////////////////////

  quiet_after_reset_a: assert property (@(posedge clk) disable iff (rst_i)
    !cmd_started |-> uart_tx_o && !psel_o)
    else abort_run("uart_tx_o or psel_o went active before the host sent anything");

  apb_setup_a: assert property (@(posedge clk) disable iff (rst_i)
    psel_o && !penable_o |=> psel_o && penable_o)
    else abort_run("APB setup phase did not last exactly one cycle");

  apb_hold_a: assert property (@(posedge clk) disable iff (rst_i)
    psel_o && penable_o && !pready_i |=>
      psel_o && penable_o && $stable(paddr_o) && $stable(pwrite_o) && $stable(pwdata_o))
    else abort_run("APB signals changed while the access phase waited");

  apb_single_a: assert property (@(posedge clk) disable iff (rst_i)
    psel_o && penable_o && pready_i |=> !penable_o)
    else abort_run("APB access phase ran on past a completed transfer");

  apb_sel_a: assert property (@(posedge clk) disable iff (rst_i)
    penable_o |-> psel_o)
    else abort_run("penable_o high without psel_o");

  // Frame receiver, sampled at mid-bit on the falling edge
  initial begin : tx_monitor
    uart_dbg_proto_pkg::byte_t b;
    forever begin
      @(negedge clk);
      if (!rst_i && uart_tx_o === 1'b0) begin
        repeat (clks_per_bit / 2) @(negedge clk);
        assert (uart_tx_o == 1'b0)
          else abort_run("Start bit on uart_tx_o shorter than half a bit");
        for (int i = 0; i < 8; i++) begin
          repeat (clks_per_bit) @(negedge clk);
          b[i] = uart_tx_o;
        end
        repeat (clks_per_bit) @(negedge clk);
        assert (uart_tx_o == 1'b1)
          else abort_run($sformatf("Mismatch at %0t ns: stop bit low on uart_tx_o", $time));
        got_q.push_back(b);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Host driver
  ////////////////////////////////////////////////////////////////////////////

  task automatic send_byte(input uart_dbg_proto_pkg::byte_t b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      uart_rx_i   <= frame[i];
      cmd_started <= 1'b1;
      repeat (clks_per_bit - 1) @(posedge clk);
    end
  endtask

  task automatic send_header(input uart_dbg_proto_pkg::byte_t cmd,
                             input uart_dbg_bus_pkg::apb_addr_t addr,
                             input uart_dbg_bus_pkg::burst_len_t len);
    send_byte(cmd);
    // Both fields go LSB first
    for (int i = 0; i < `UART_DBG_ADDR_BYTES; i++) begin
      send_byte(addr[8*i +: 8]);
    end
    for (int i = 0; i < `UART_DBG_LEN_BYTES; i++) begin
      send_byte(len[8*i +: 8]);
    end
  endtask

  task automatic expect_byte(input uart_dbg_proto_pkg::byte_t exp_byte, input string what);
    uart_dbg_proto_pkg::byte_t got;
    while (got_q.size() == 0) begin
      @(negedge clk);
    end
    got = got_q.pop_front();
    assert (got == exp_byte)
      else abort_run($sformatf("Mismatch at %0t ns: %s got %h, expected %h",
                               $time, what, got, exp_byte));
  endtask

  task automatic check_quiet(input string what);
    // Two frame times
    repeat (20 * clks_per_bit) @(negedge clk);
    assert (got_q.size() == 0)
      else abort_run($sformatf("Mismatch at %0t ns: extra frame after %s", $time, what));
  endtask

  task automatic write_burst(input uart_dbg_bus_pkg::apb_addr_t addr, input int len);
    uart_dbg_bus_pkg::apb_addr_t a;
    uart_dbg_bus_pkg::apb_data_t data;
    int                          start_cnt;
    start_cnt = xfer_cnt;
    send_header(uart_dbg_proto_pkg::CMD_WRITE, addr, uart_dbg_bus_pkg::burst_len_t'(len));
    expect_byte(uart_dbg_proto_pkg::RESP_ACK, "write header ACK");
    for (int i = 0; i < len; i++) begin
      a    = addr + uart_dbg_bus_pkg::apb_addr_t'(i);
      data = uart_dbg_bus_pkg::apb_data_t'($urandom());
      exp_mem[a] = data;
      exp_addr_q.push_back(a);
      exp_data_q.push_back(data);
      send_byte(data);
    end
    expect_byte(uart_dbg_proto_pkg::RESP_EOT, "write EOT");
    assert (xfer_cnt - start_cnt == len && exp_addr_q.size() == 0)
      else abort_run($sformatf("Mismatch at %0t ns: %0d APB transfers for a write of %0d",
                               $time, xfer_cnt - start_cnt, len));
    check_quiet("write burst");
  endtask

  task automatic read_burst(input uart_dbg_bus_pkg::apb_addr_t addr, input int len);
    uart_dbg_bus_pkg::apb_addr_t a;
    uart_dbg_proto_pkg::byte_t   exp_byte;
    int                          start_cnt;
    start_cnt = xfer_cnt;
    send_header(uart_dbg_proto_pkg::CMD_READ, addr, uart_dbg_bus_pkg::burst_len_t'(len));
    expect_byte(uart_dbg_proto_pkg::RESP_ACK, "read header ACK");
    for (int i = 0; i < len; i++) begin
      a = addr + uart_dbg_bus_pkg::apb_addr_t'(i);
      // Bytes never written keep the preset value
      exp_byte = exp_mem.exists(a) ? exp_mem[a] : 8'h9a;
      expect_byte(exp_byte, $sformatf("read data at %h", a));
    end
    expect_byte(uart_dbg_proto_pkg::RESP_EOT, "read EOT");
    assert (xfer_cnt - start_cnt == len)
      else abort_run($sformatf("Mismatch at %0t ns: %0d APB transfers for a read of %0d",
                               $time, xfer_cnt - start_cnt, len));
    check_quiet("read burst");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    uart_dbg_bus_pkg::apb_addr_t base;
    int                          len;
    void'($urandom(94537));
    rst_i       = 1'b1;
    uart_rx_i   = 1'b1;
    prdata_i    = '0;
    pready_i    = 1'b0;
    cmd_started = 1'b0;
    repeat (5) @(posedge clk);
    rst_i <= 1'b0;
    // Line and bus must stay idle here
    repeat (20 * clks_per_bit) @(posedge clk);

    send_byte(uart_dbg_proto_pkg::RESP_ACK);
    expect_byte(uart_dbg_proto_pkg::RESP_ACK, "challenge reply");
    check_quiet("ACK challenge");

    base = $urandom();
    len  = $urandom_range(16, 1);
    write_burst(base, len);
    // Two bytes past the written region
    read_burst(base, len + 2);
    write_burst($urandom(), 0);

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// ==== logic/uart_dbg_top.sv ====
`timescale 1ns/1ps
`include "uart_dbg_defines.svh"

module uart_dbg_top (
  input  logic                            clk,
  input  logic                            rst_i,
  input  logic                            uart_rx_i,
  output logic                            uart_tx_o,
  output logic                            psel_o,
  output logic                            penable_o,
  output logic                            pwrite_o,
  output logic [`UART_DBG_APB_ADDR_W-1:0] paddr_o,
  output logic [`UART_DBG_APB_DATA_W-1:0] pwdata_o,
  input  logic [`UART_DBG_APB_DATA_W-1:0] prdata_i,
  input  logic                            pready_i
);

  logic                      rx_valid;
  uart_dbg_proto_pkg::byte_t rx_byte;
  logic                      push;
  uart_dbg_proto_pkg::byte_t push_byte;
  logic                      q_full;
  logic                      tx_valid;
  uart_dbg_proto_pkg::byte_t tx_byte;
  logic                      tx_ready;

  ////////////////////////////////////////////////////////////////////////////
  // Receive, decode, queue, transmit
  ////////////////////////////////////////////////////////////////////////////

  uart_rx_deser u_rx (
    .clk       (clk),
    .rst_i     (rst_i),
    .uart_rx_i (uart_rx_i),
    .rx_valid_o(rx_valid),
    .rx_byte_o (rx_byte)
  );

  dbg_cmd_engine u_engine (
    .clk        (clk),
    .rst_i      (rst_i),
    .rx_valid_i (rx_valid),
    .rx_byte_i  (rx_byte),
    .push_o     (push),
    .push_byte_o(push_byte),
    .q_full_i   (q_full),
    .psel_o     (psel_o),
    .penable_o  (penable_o),
    .pwrite_o   (pwrite_o),
    .paddr_o    (paddr_o),
    .pwdata_o   (pwdata_o),
    .prdata_i   (prdata_i),
    .pready_i   (pready_i)
  );

  tx_byte_queue u_txq (
    .clk        (clk),
    .rst_i      (rst_i),
    .push_i     (push),
    .push_byte_i(push_byte),
    .full_o     (q_full),
    .tx_valid_o (tx_valid),
    .tx_byte_o  (tx_byte),
    .tx_ready_i (tx_ready)
  );

  uart_tx_ser u_tx (
    .clk       (clk),
    .rst_i     (rst_i),
    .tx_valid_i(tx_valid),
    .tx_byte_i (tx_byte),
    .tx_ready_o(tx_ready),
    .uart_tx_o (uart_tx_o)
  );

endmodule

// ==== logic/uart_tx_ser.sv ====
`timescale 1ns/1ps
`include "uart_dbg_defines.svh"

module uart_tx_ser (
  input  logic                      clk,
  input  logic                      rst_i,
  input  logic                      tx_valid_i,
  input  uart_dbg_proto_pkg::byte_t tx_byte_i,
  output logic                      tx_ready_o,
  output logic                      uart_tx_o
);

  localparam int clks_per_bit = `UART_DBG_CLKS_PER_BIT;
  localparam int cnt_w        = $clog2(clks_per_bit);
  localparam int frame_bits   = 10;
  localparam int bit_w        = $clog2(frame_bits);

  typedef enum logic {
    TX_IDLE,
    TX_SHIFT
  } tx_state_e;

  tx_state_e              state_q;
  logic [cnt_w-1:0]       clk_cnt_q;
  logic [bit_w-1:0]       bit_cnt_q;
  logic [frame_bits-1:0]  frame_q;
  logic                   bit_end;

  assign bit_end    = clk_cnt_q == cnt_w'(clks_per_bit - 1);
  assign tx_ready_o = state_q == TX_IDLE;
  // Line idles high between frames
  assign uart_tx_o  = (state_q == TX_SHIFT) ? frame_q[0] : 1'b1;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q   <= TX_IDLE;
      clk_cnt_q <= '0;
      bit_cnt_q <= '0;
    end else if (state_q == TX_IDLE) begin
      clk_cnt_q <= '0;
      bit_cnt_q <= '0;
      if (tx_valid_i) begin
        state_q <= TX_SHIFT;
      end
    end else begin
      clk_cnt_q <= clk_cnt_q + 1'b1;
      if (bit_end) begin
        clk_cnt_q <= '0;
        bit_cnt_q <= bit_cnt_q + 1'b1;
        // Stop bit done
        if (bit_cnt_q == bit_w'(frame_bits - 1)) begin
          state_q <= TX_IDLE;
        end
      end
    end
  end

  // Start bit in bit 0, stop bit fills from the top
  always_ff @(posedge clk) begin
    if (state_q == TX_IDLE && tx_valid_i) begin
      frame_q <= {1'b1, tx_byte_i, 1'b0};
    end else if (state_q == TX_SHIFT && bit_end) begin
      frame_q <= {1'b1, frame_q[frame_bits-1:1]};
    end
  end

endmodule

// ==== logic/tx_byte_queue.sv ====
`timescale 1ns/1ps
`include "uart_dbg_defines.svh"

module tx_byte_queue (
  input  logic                      clk,
  input  logic                      rst_i,
  input  logic                      push_i,
  input  uart_dbg_proto_pkg::byte_t push_byte_i,
  output logic                      full_o,
  output logic                      tx_valid_o,
  output uart_dbg_proto_pkg::byte_t tx_byte_o,
  input  logic                      tx_ready_i
);

  localparam int depth = `UART_DBG_TXQ_DEPTH;
  localparam int ptr_w = $clog2(depth);

  uart_dbg_proto_pkg::byte_t mem_q [depth];
  // Extra MSB tells full from empty
  logic [ptr_w:0]            wr_ptr_q;
  logic [ptr_w:0]            rd_ptr_q;
  logic                      pop;

  assign pop        = tx_valid_o && tx_ready_i;
  assign tx_valid_o = wr_ptr_q != rd_ptr_q;
  assign full_o     = (wr_ptr_q[ptr_w] != rd_ptr_q[ptr_w]) &&
                      (wr_ptr_q[ptr_w-1:0] == rd_ptr_q[ptr_w-1:0]);
  assign tx_byte_o  = mem_q[rd_ptr_q[ptr_w-1:0]];

  always_ff @(posedge clk) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push_i && !full_o) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push_i && !full_o) begin
      mem_q[wr_ptr_q[ptr_w-1:0]] <= push_byte_i;
    end
  end

  // Engine holds off while the queue is full
  no_push_when_full_a: assert property (@(posedge clk) disable iff (rst_i)
    push_i |-> !full_o);

endmodule

// ==== logic/dbg_cmd_engine.sv ====
`timescale 1ns/1ps
`include "uart_dbg_defines.svh"

module dbg_cmd_engine (
  input  logic                        clk,
  input  logic                        rst_i,
  input  logic                        rx_valid_i,
  input  uart_dbg_proto_pkg::byte_t   rx_byte_i,
  output logic                        push_o,
  output uart_dbg_proto_pkg::byte_t   push_byte_o,
  input  logic                        q_full_i,
  output logic                        psel_o,
  output logic                        penable_o,
  output logic                        pwrite_o,
  output uart_dbg_bus_pkg::apb_addr_t paddr_o,
  output uart_dbg_bus_pkg::apb_data_t pwdata_o,
  input  uart_dbg_bus_pkg::apb_data_t prdata_i,
  input  logic                        pready_i
);

  localparam int hdr_bytes = `UART_DBG_ADDR_BYTES + `UART_DBG_LEN_BYTES;

  uart_dbg_proto_pkg::engine_state_e state_q;
  uart_dbg_proto_pkg::hdr_cnt_t      hdr_cnt_q;
  logic                              cmd_read_q;
  uart_dbg_bus_pkg::burst_len_t      idx_q;
  logic                              penable_q;
  uart_dbg_bus_pkg::apb_addr_t       addr_q;
  uart_dbg_bus_pkg::burst_len_t      len_q;
  uart_dbg_bus_pkg::apb_data_t       data_q;
  logic                              is_cmd;
  logic                              apb_done;
  logic                              last_xfer;

  assign is_cmd = (rx_byte_i == uart_dbg_proto_pkg::CMD_READ) ||
                  (rx_byte_i == uart_dbg_proto_pkg::CMD_WRITE);
  assign apb_done  = penable_q && pready_i;
  assign last_xfer = idx_q == uart_dbg_bus_pkg::burst_len_t'(len_q - 1'b1);

  ////////////////////////////////////////////////////////////////////////////
  // Command FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q    <= uart_dbg_proto_pkg::ST_IDLE;
      hdr_cnt_q  <= '0;
      cmd_read_q <= 1'b0;
      idx_q      <= '0;
      penable_q  <= 1'b0;
    end else begin
      case (state_q)
        uart_dbg_proto_pkg::ST_IDLE: begin
          hdr_cnt_q <= '0;
          if (rx_valid_i) begin
            // ACK challenge from the host
            if (rx_byte_i == uart_dbg_proto_pkg::RESP_ACK) begin
              state_q <= uart_dbg_proto_pkg::ST_CHAL;
            end else if (is_cmd) begin
              cmd_read_q <= rx_byte_i == uart_dbg_proto_pkg::CMD_READ;
              state_q    <= uart_dbg_proto_pkg::ST_HDR;
            end
          end
        end
        uart_dbg_proto_pkg::ST_CHAL: begin
          if (push_o) begin
            state_q <= uart_dbg_proto_pkg::ST_IDLE;
          end
        end
        uart_dbg_proto_pkg::ST_HDR: begin
          if (rx_valid_i) begin
            hdr_cnt_q <= hdr_cnt_q + 1'b1;
            if (hdr_cnt_q == uart_dbg_proto_pkg::hdr_cnt_t'(hdr_bytes - 1)) begin
              state_q <= uart_dbg_proto_pkg::ST_ACK;
            end
          end
        end
        uart_dbg_proto_pkg::ST_ACK: begin
          idx_q <= '0;
          if (push_o) begin
            if (len_q == '0) begin
              state_q <= uart_dbg_proto_pkg::ST_EOT;
            end else if (cmd_read_q) begin
              state_q <= uart_dbg_proto_pkg::ST_RD_APB;
            end else begin
              state_q <= uart_dbg_proto_pkg::ST_WR_WAIT;
            end
          end
        end
        uart_dbg_proto_pkg::ST_WR_WAIT: begin
          if (rx_valid_i) begin
            state_q <= uart_dbg_proto_pkg::ST_WR_APB;
          end
        end
        uart_dbg_proto_pkg::ST_WR_APB: begin
          penable_q <= !apb_done;
          if (apb_done) begin
            idx_q   <= idx_q + 1'b1;
            state_q <= last_xfer ? uart_dbg_proto_pkg::ST_EOT : uart_dbg_proto_pkg::ST_WR_WAIT;
          end
        end
        uart_dbg_proto_pkg::ST_RD_APB: begin
          penable_q <= !apb_done;
          if (apb_done) begin
            state_q <= uart_dbg_proto_pkg::ST_RD_PUSH;
          end
        end
        uart_dbg_proto_pkg::ST_RD_PUSH: begin
          // Next read waits for queue space
          if (push_o) begin
            idx_q   <= idx_q + 1'b1;
            state_q <= last_xfer ? uart_dbg_proto_pkg::ST_EOT : uart_dbg_proto_pkg::ST_RD_APB;
          end
        end
        default: begin
          if (push_o) begin
            state_q <= uart_dbg_proto_pkg::ST_IDLE;
          end
        end
      endcase
    end
  end

  // Header fields shift in LSB first
  always_ff @(posedge clk) begin
    if (state_q == uart_dbg_proto_pkg::ST_HDR && rx_valid_i) begin
      if (hdr_cnt_q < `UART_DBG_ADDR_BYTES) begin
        addr_q <= {rx_byte_i, addr_q[$bits(addr_q)-1:8]};
      end else begin
        len_q <= {rx_byte_i, len_q[$bits(len_q)-1:8]};
      end
    end
    if (state_q == uart_dbg_proto_pkg::ST_WR_WAIT && rx_valid_i) begin
      data_q <= rx_byte_i;
    end
    if (state_q == uart_dbg_proto_pkg::ST_RD_APB && apb_done) begin
      data_q <= prdata_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    push_o      = 1'b0;
    push_byte_o = uart_dbg_proto_pkg::byte_t'(uart_dbg_proto_pkg::RESP_ACK);
    case (state_q)
      uart_dbg_proto_pkg::ST_CHAL,
      uart_dbg_proto_pkg::ST_ACK: begin
        push_o = !q_full_i;
      end
      uart_dbg_proto_pkg::ST_RD_PUSH: begin
        push_o      = !q_full_i;
        push_byte_o = data_q;
      end
      uart_dbg_proto_pkg::ST_EOT: begin
        push_o      = !q_full_i;
        push_byte_o = uart_dbg_proto_pkg::byte_t'(uart_dbg_proto_pkg::RESP_EOT);
      end
      default: begin
        push_o = 1'b0;
      end
    endcase
  end

  // Address holds across the transfer since idx moves only on completion
  assign psel_o    = (state_q == uart_dbg_proto_pkg::ST_WR_APB) ||
                     (state_q == uart_dbg_proto_pkg::ST_RD_APB);
  assign penable_o = penable_q;
  assign pwrite_o  = state_q == uart_dbg_proto_pkg::ST_WR_APB;
  assign paddr_o   = addr_q + uart_dbg_bus_pkg::apb_addr_t'(idx_q);
  assign pwdata_o  = data_q;

  apb_hold_a: assert property (@(posedge clk) disable iff (rst_i)
    psel_o && penable_o && !pready_i |=>
      psel_o && $stable(paddr_o) && $stable(pwdata_o) && $stable(pwrite_o));

  // Access phase only after a setup cycle
  apb_setup_a: assert property (@(posedge clk) disable iff (rst_i)
    $rose(penable_o) |-> psel_o && $past(psel_o));

endmodule

// ==== logic/uart_rx_deser.sv ====
`timescale 1ns/1ps
`include "uart_dbg_defines.svh"

module uart_rx_deser (
  input  logic                      clk,
  input  logic                      rst_i,
  input  logic                      uart_rx_i,
  output logic                      rx_valid_o,
  output uart_dbg_proto_pkg::byte_t rx_byte_o
);

  localparam int clks_per_bit = `UART_DBG_CLKS_PER_BIT;
  localparam int cnt_w        = $clog2(clks_per_bit);

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_e;

  rx_state_e                 state_q;
  logic                      rx_meta_q;
  logic                      rx_sync_q;
  logic                      rx_prev_q;
  logic [cnt_w-1:0]          clk_cnt_q;
  logic [2:0]                bit_cnt_q;
  logic                      rx_valid_q;
  uart_dbg_proto_pkg::byte_t shift_q;
  logic                      start_edge;
  logic                      half_end;
  logic                      bit_end;

  assign start_edge = rx_prev_q && !rx_sync_q;
  assign half_end   = clk_cnt_q == cnt_w'(clks_per_bit / 2 - 1);
  assign bit_end    = clk_cnt_q == cnt_w'(clks_per_bit - 1);

  // Two flop synchronizer, line idles high
  always_ff @(posedge clk) begin
    if (rst_i) begin
      rx_meta_q <= 1'b1;
      rx_sync_q <= 1'b1;
      rx_prev_q <= 1'b1;
    end else begin
      rx_meta_q <= uart_rx_i;
      rx_sync_q <= rx_meta_q;
      rx_prev_q <= rx_sync_q;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q    <= RX_IDLE;
      clk_cnt_q  <= '0;
      bit_cnt_q  <= '0;
      rx_valid_q <= 1'b0;
    end else begin
      rx_valid_q <= 1'b0;
      case (state_q)
        RX_IDLE: begin
          clk_cnt_q <= '0;
          if (start_edge) begin
            state_q <= RX_START;
          end
        end
        RX_START: begin
          clk_cnt_q <= clk_cnt_q + 1'b1;
          // Glitch check at the middle of the start bit
          if (half_end) begin
            clk_cnt_q <= '0;
            bit_cnt_q <= '0;
            state_q   <= rx_sync_q ? RX_IDLE : RX_DATA;
          end
        end
        RX_DATA: begin
          clk_cnt_q <= clk_cnt_q + 1'b1;
          if (bit_end) begin
            clk_cnt_q <= '0;
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == 3'd7) begin
              state_q <= RX_STOP;
            end
          end
        end
        default: begin
          clk_cnt_q <= clk_cnt_q + 1'b1;
          // Framing error drops the byte
          if (bit_end) begin
            rx_valid_q <= rx_sync_q;
            state_q    <= RX_IDLE;
          end
        end
      endcase
    end
  end

  // Data bits arrive LSB first
  always_ff @(posedge clk) begin
    if (state_q == RX_DATA && bit_end) begin
      shift_q <= {rx_sync_q, shift_q[7:1]};
    end
  end

  assign rx_valid_o = rx_valid_q;
  assign rx_byte_o  = shift_q;

  rx_valid_pulse_a: assert property (@(posedge clk) disable iff (rst_i)
    rx_valid_o |=> !rx_valid_o);

endmodule

// ==== logic/uart_dbg_bus_pkg.sv ====
`include "uart_dbg_defines.svh"

package uart_dbg_bus_pkg;

  // Byte address on the APB side
  typedef logic [`UART_DBG_APB_ADDR_W-1:0] apb_addr_t;

  // One byte per APB transfer
  typedef logic [`UART_DBG_APB_DATA_W-1:0] apb_data_t;

  // Burst length as carried in the command header
  typedef logic [`UART_DBG_LEN_BYTES*8-1:0] burst_len_t;

endpackage

// ==== logic/uart_dbg_proto_pkg.sv ====
`include "uart_dbg_defines.svh"

package uart_dbg_proto_pkg;

  // One character on the serial line
  typedef logic [7:0] byte_t;

  // Position within the address and length fields of a header
  typedef logic [$clog2(`UART_DBG_ADDR_BYTES + `UART_DBG_LEN_BYTES)-1:0] hdr_cnt_t;

  // Host command codes
  typedef enum logic [7:0] {
    CMD_READ  = 8'h11,
    CMD_WRITE = 8'h12
  } cmd_e;

  // Framing bytes sent back to the host
  typedef enum logic [7:0] {
    RESP_EOT = 8'h04,
    RESP_ACK = 8'h06
  } resp_e;

  // Command engine FSM
  typedef enum logic [3:0] {
    ST_IDLE,
    ST_CHAL,
    ST_HDR,
    ST_ACK,
    ST_WR_WAIT,
    ST_WR_APB,
    ST_RD_APB,
    ST_RD_PUSH,
    ST_EOT
  } engine_state_e;

endpackage

// ==== logic/uart_dbg_defines.svh ====
`ifndef UART_DBG_DEFINES_SVH
`define UART_DBG_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// Serial timing
////////////////////////////////////////////////////////////////////////////

// Clock cycles per serial bit
`define UART_DBG_CLKS_PER_BIT 16

////////////////////////////////////////////////////////////////////////////
// Command header fields
////////////////////////////////////////////////////////////////////////////

// Address field, sent LSB first
`define UART_DBG_ADDR_BYTES 4

// Length field, sent LSB first
`define UART_DBG_LEN_BYTES 2

////////////////////////////////////////////////////////////////////////////
// APB master and transmit path
////////////////////////////////////////////////////////////////////////////

`define UART_DBG_APB_ADDR_W 32
`define UART_DBG_APB_DATA_W 8

// Response bytes buffered ahead of the transmitter
`define UART_DBG_TXQ_DEPTH 4

`endif
